// ==== design/posit_cfg.svh ====
/* Posit format and lane count for the vector multiplier
   Decode and pack logic assume es = 1; other es values are not supported */
`ifndef POSIT_CFG_SVH
`define POSIT_CFG_SVH

`define POSIT_N   16                          // Posit word width
`define POSIT_ES  1                           // Exponent bits
`define LANES     4                           // Parallel multipliers

// Raw fraction without hidden bit
`define FRAC_W    (`POSIT_N - 3 - `POSIT_ES)

// Signed scale wide enough for the product of two posits
`define SCALE_W   8

`endif

// ==== design/posit_pkg.sv ====
/* Types for posit words and raw serialized fields
   Vector types hold LANES elements with lane 0 in the low bits */
`include "posit_cfg.svh"

package posit_pkg;

    // Single values
    typedef logic [`POSIT_N-1:0]        posit_t;
    typedef logic signed [`SCALE_W-1:0] scale_t;
    typedef logic [`FRAC_W-1:0]         frac_t;

    // Product fraction keeps every bit of the mantissa product
    typedef logic [2*`FRAC_W:0]         pfrac_t;

    // Per-lane vectors
    typedef posit_t [`LANES-1:0]        posit_vec_t;
    typedef scale_t [`LANES-1:0]        scale_vec_t;
    typedef frac_t  [`LANES-1:0]        frac_vec_t;
    typedef pfrac_t [`LANES-1:0]        pfrac_vec_t;

endpackage

// ==== design/posit_unpack.sv ====
/* Decodes both operand vectors to raw fields in one register stage
   0x0000 sets zero, 0x8000 sets inf; all other raw fields are 0 for either */
`timescale 1ns/1ps
`include "posit_cfg.svh"

module posit_unpack (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  posit_pkg::posit_vec_t a_vec,
    input  posit_pkg::posit_vec_t b_vec,
    output logic                  dec_valid,
    output logic [`LANES-1:0]     a_sgn,
    output logic [`LANES-1:0]     a_inf,
    output logic [`LANES-1:0]     a_zero,
    output logic [`LANES-1:0]     b_sgn,
    output logic [`LANES-1:0]     b_inf,
    output logic [`LANES-1:0]     b_zero,
    output posit_pkg::scale_vec_t a_scale,
    output posit_pkg::scale_vec_t b_scale,
    output posit_pkg::frac_vec_t  a_frac,
    output posit_pkg::frac_vec_t  b_frac
);
    import posit_pkg::*;

    localparam int OPS = 2 * `LANES;          // a operands low, b operands high
    localparam int BW  = `POSIT_N - 1;        // Body without sign bit
    localparam int RW  = $clog2(`POSIT_N);

    posit_t [OPS-1:0] op;
    logic   [OPS-1:0] sgn_d, inf_d, zero_d;
    scale_t [OPS-1:0] scale_d;
    frac_t  [OPS-1:0] frac_d;
    logic   [OPS-1:0] sgn_q, inf_q, zero_q;
    scale_t [OPS-1:0] scale_q;
    frac_t  [OPS-1:0] frac_q;

    assign op = {b_vec, a_vec};

    for (genvar i = 0; i < OPS; i++) begin : g_dec
        posit_t        mag;
        logic [BW-1:0] body;
        logic [BW-1:0] rest;
        logic [RW-1:0] run;
        logic [RW:0]   shamt;
        logic          stop;
        logic          is_zero;
        logic          is_nar;
        scale_t        k;

        always_comb
        begin
            is_zero = (op[i] == '0);
            is_nar  = op[i][`POSIT_N-1] & ~|op[i][BW-1:0];
            mag     = op[i][`POSIT_N-1] ? -op[i] : op[i];
            body    = mag[BW-1:0];

            // Length of the regime run
            run  = '0;
            stop = 1'b0;
            for (int j = BW - 1; j >= 0; j--)
            begin
                if (!stop && body[j] == body[BW-1])
                    run = run + 1'b1;
                else
                    stop = 1'b1;
            end

            shamt = {1'b0, run} + 1'b1;
            rest  = body << shamt;            // Exponent bit now at the top

            if (body[BW-1])
                k = scale_t'(run) - scale_t'(1);
            else
                k = -scale_t'(run);

            if (is_zero || is_nar)
            begin
                sgn_d[i]   = 1'b0;
                scale_d[i] = '0;
                frac_d[i]  = '0;
            end
            else
            begin
                sgn_d[i]   = op[i][`POSIT_N-1];
                scale_d[i] = {k[`SCALE_W-2:0], rest[BW-1]};   // 2k + e
                frac_d[i]  = rest[BW-2 -: `FRAC_W];
            end
            inf_d[i]  = is_nar;
            zero_d[i] = is_zero;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            dec_valid <= 1'b0;
        else
            dec_valid <= start;
    end

    always_ff @(posedge clk)
    begin
        sgn_q   <= sgn_d;
        inf_q   <= inf_d;
        zero_q  <= zero_d;
        scale_q <= scale_d;
        frac_q  <= frac_d;
    end

    assign a_sgn   = sgn_q[`LANES-1:0];
    assign a_inf   = inf_q[`LANES-1:0];
    assign a_zero  = zero_q[`LANES-1:0];
    assign a_scale = scale_q[`LANES-1:0];
    assign a_frac  = frac_q[`LANES-1:0];
    assign b_sgn   = sgn_q[OPS-1:`LANES];
    assign b_inf   = inf_q[OPS-1:`LANES];
    assign b_zero  = zero_q[OPS-1:`LANES];
    assign b_scale = scale_q[OPS-1:`LANES];
    assign b_frac  = frac_q[OPS-1:`LANES];

endmodule

// ==== design/raw_mult_lane.sv ====
/* Two-stage raw multiplier for one lane, two cycles from in_valid to out_valid
   Output fraction drops the hidden bit and keeps all other product bits */
`timescale 1ns/1ps

module raw_mult_lane (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic              a_sgn,
    input  logic              a_inf,
    input  logic              a_zero,
    input  logic              b_sgn,
    input  logic              b_inf,
    input  logic              b_zero,
    input  posit_pkg::scale_t a_scale,
    input  posit_pkg::scale_t b_scale,
    input  posit_pkg::frac_t  a_frac,
    input  posit_pkg::frac_t  b_frac,
    output logic              out_valid,
    output logic              p_sgn,
    output logic              p_inf,
    output logic              p_zero,
    output posit_pkg::scale_t p_scale,
    output posit_pkg::pfrac_t p_frac
);
    import posit_pkg::*;

    localparam int HW = $bits(frac_t) + 1;    // Mantissa with hidden bit
    localparam int MW = 2 * HW;

    logic          r1_valid;
    logic          r1_a_sgn, r1_a_inf, r1_a_zero;
    logic          r1_b_sgn, r1_b_inf, r1_b_zero;
    scale_t        r1_a_scale, r1_b_scale;
    frac_t         r1_a_frac, r1_b_frac;

    logic [HW-1:0] a_man, b_man;
    logic [MW-1:0] prod;
    logic          top;
    logic          any_inf;
    scale_t        n_scale;
    pfrac_t        n_frac;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            r1_valid <= 1'b0;
        else
            r1_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        r1_a_sgn   <= a_sgn;
        r1_a_inf   <= a_inf;
        r1_a_zero  <= a_zero;
        r1_a_scale <= a_scale;
        r1_a_frac  <= a_frac;
        r1_b_sgn   <= b_sgn;
        r1_b_inf   <= b_inf;
        r1_b_zero  <= b_zero;
        r1_b_scale <= b_scale;
        r1_b_frac  <= b_frac;
    end

    assign a_man = {1'b1, r1_a_frac};
    assign b_man = {1'b1, r1_b_frac};
    assign prod  = a_man * b_man;             // Product lies in [1, 4)
    assign top   = prod[MW-1];

    // Normalize so the hidden bit sits just above p_frac
    assign n_scale = r1_a_scale + r1_b_scale + scale_t'(top);
    assign n_frac  = top ? prod[MW-2:0] : {prod[MW-3:0], 1'b0};
    assign any_inf = r1_a_inf | r1_b_inf;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= r1_valid;
    end

    always_ff @(posedge clk)
    begin
        p_sgn   <= r1_a_sgn ^ r1_b_sgn;
        p_inf   <= any_inf;
        p_zero  <= (r1_a_zero | r1_b_zero) & ~any_inf;   // NaR wins over zero
        p_scale <= n_scale;
        p_frac  <= n_frac;
    end

endmodule

// ==== design/posit_pack.sv ====
/* Rounds raw products to posits in one register stage, nearest with ties to even
   Results saturate at maxpos and minpos, never rounding to zero or NaR */
`timescale 1ns/1ps
`include "posit_cfg.svh"

module posit_pack (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [`LANES-1:0]     p_sgn,
    input  logic [`LANES-1:0]     p_inf,
    input  logic [`LANES-1:0]     p_zero,
    input  posit_pkg::scale_vec_t p_scale,
    input  posit_pkg::pfrac_vec_t p_frac,
    output logic                  done,
    output posit_pkg::posit_vec_t p_vec
);
    import posit_pkg::*;

    localparam int BW        = `POSIT_N - 1;               // Body without sign bit
    localparam int XW        = `POSIT_N + 2 * `FRAC_W + 4; // Regime, exponent, fraction
    localparam int SW        = $clog2(XW);
    localparam int PADW      = XW - 2 - $bits(pfrac_t);
    localparam int MAX_SCALE = (`POSIT_N - 2) << `POSIT_ES;

    posit_vec_t p_d;

    for (genvar i = 0; i < `LANES; i++) begin : g_enc
        scale_t        s;
        scale_t        k;
        scale_t        nk;
        logic [SW-1:0] shamt;
        logic [XW-1:0] x;
        logic [BW-1:0] body;
        logic [BW-1:0] mag;
        logic          guard;
        logic          sticky;
        logic          rnd;
        posit_t        enc;

        always_comb
        begin
            s  = p_scale[i];
            k  = s >>> 1;                     // Regime value with s[0] as exponent bit
            nk = -k;

            // Regime run, terminator, exponent and fraction left-aligned in x
            if (k >= 0)
            begin
                shamt = k[SW-1:0] + 1'b1;
                x = ({1'b0, s[0], p_frac[i], {PADW{1'b0}}} >> shamt)
                    | ~({XW{1'b1}} >> shamt);
            end
            else
            begin
                shamt = nk[SW-1:0];
                x = {1'b1, s[0], p_frac[i], {PADW{1'b0}}} >> shamt;
            end

            body   = x[XW-1 -: BW];
            guard  = x[XW-1-BW];
            sticky = |x[XW-2-BW:0];
            rnd    = guard & (sticky | body[0]);   // Ties go to the even pattern
            mag    = body + {{(BW-1){1'b0}}, rnd};

            if (s >= MAX_SCALE)
                mag = '1;                     // maxpos
            else if (s < -MAX_SCALE)
                mag = {{(BW-1){1'b0}}, 1'b1}; // minpos

            if (p_inf[i])
                enc = {1'b1, {BW{1'b0}}};
            else if (p_zero[i])
                enc = '0;
            else if (p_sgn[i])
                enc = -{1'b0, mag};
            else
                enc = {1'b0, mag};
        end

        assign p_d[i] = enc;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            done <= 1'b0;
        else
            done <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        p_vec <= p_d;
    end

endmodule

// ==== design/posit_vec_mult.sv ====
/* Four-lane posit(16,1) multiplier with done and p_vec four cycles after start
   Fully pipelined with no stall; a new start is accepted on every cycle */
`timescale 1ns/1ps
`include "posit_cfg.svh"

module posit_vec_mult (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  posit_pkg::posit_vec_t a_vec,
    input  posit_pkg::posit_vec_t b_vec,
    output logic                  done,
    output posit_pkg::posit_vec_t p_vec
);
    import posit_pkg::*;

    logic              dec_valid;
    logic [`LANES-1:0] a_sgn, a_inf, a_zero;
    logic [`LANES-1:0] b_sgn, b_inf, b_zero;
    scale_vec_t        a_scale, b_scale;
    frac_vec_t         a_frac, b_frac;

    logic [`LANES-1:0] mul_valid;             // Identical per lane
    logic [`LANES-1:0] p_sgn, p_inf, p_zero;
    scale_vec_t        p_scale;
    pfrac_vec_t        p_frac;

    posit_unpack u_posit_unpack (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .a_vec     (a_vec),
        .b_vec     (b_vec),
        .dec_valid (dec_valid),
        .a_sgn     (a_sgn),
        .a_inf     (a_inf),
        .a_zero    (a_zero),
        .b_sgn     (b_sgn),
        .b_inf     (b_inf),
        .b_zero    (b_zero),
        .a_scale   (a_scale),
        .b_scale   (b_scale),
        .a_frac    (a_frac),
        .b_frac    (b_frac)
    );

    for (genvar i = 0; i < `LANES; i++) begin : g_lane
        raw_mult_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (dec_valid),
            .a_sgn     (a_sgn[i]),
            .a_inf     (a_inf[i]),
            .a_zero    (a_zero[i]),
            .b_sgn     (b_sgn[i]),
            .b_inf     (b_inf[i]),
            .b_zero    (b_zero[i]),
            .a_scale   (a_scale[i]),
            .b_scale   (b_scale[i]),
            .a_frac    (a_frac[i]),
            .b_frac    (b_frac[i]),
            .out_valid (mul_valid[i]),
            .p_sgn     (p_sgn[i]),
            .p_inf     (p_inf[i]),
            .p_zero    (p_zero[i]),
            .p_scale   (p_scale[i]),
            .p_frac    (p_frac[i])
        );
    end

    posit_pack u_posit_pack (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (mul_valid[0]),
        .p_sgn    (p_sgn),
        .p_inf    (p_inf),
        .p_zero   (p_zero),
        .p_scale  (p_scale),
        .p_frac   (p_frac),
        .done     (done),
        .p_vec    (p_vec)
    );

endmodule

// ==== dv/posit_vec_mult_asserts.sv ====
/* Strobe timing and NaR propagation checks, bound into posit_vec_mult
   Needs assertion support enabled in the simulator */
`timescale 1ns/1ps
`include "posit_cfg.svh"

module posit_vec_mult_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  start,
    input posit_pkg::posit_vec_t a_vec,
    input posit_pkg::posit_vec_t b_vec,
    input logic                  done,
    input posit_pkg::posit_vec_t p_vec
);
    import posit_pkg::*;

    // Reset clears the done strobe
    assert property (@(posedge clk) !rst_n |=> !done)
        else $error("done is high after reset");

    assert property (@(posedge clk) disable iff (!rst_n) done == $past(start, 4))
        else $error("done does not follow start by four cycles");

    for (genvar i = 0; i < `LANES; i++) begin : g_nar
        assert property (@(posedge clk) disable iff (!rst_n)
            $past(start && (a_vec[i] == 16'h8000 || b_vec[i] == 16'h8000), 4)
            |-> p_vec[i] == 16'h8000)
            else $error("lane %0d dropped a NaR operand", i);
    end

endmodule

bind posit_vec_mult posit_vec_mult_asserts u_posit_vec_mult_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .a_vec (a_vec),
    .b_vec (b_vec),
    .done  (done),
    .p_vec (p_vec)
);

// ==== dv/posit_vec_mult_tb.sv ====
/* Random testbench for the four-lane posit(16,1) multiplier
   The reference model is exact for es = 1 only. Products are due four cycles after start */
`timescale 1ns/1ps
`include "posit_cfg.svh"

module posit_vec_mult_tb;
    import posit_pkg::*;

    localparam int STIM_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 1000;   // Reset and drain fit well inside
    localparam int LATENCY        = 4;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start;
    posit_vec_t a_vec;
    posit_vec_t b_vec;
    logic       done;
    posit_vec_t p_vec;

    posit_vec_t exp_q[$];                     // Expected products, oldest first
    int         due_q[$];                     // Cycle at which each item must finish
    posit_vec_t exp_vec;
    int         due;
    int         lane;
    int         cycle  = 0;
    int         errors = 0;

    posit_vec_mult u_posit_vec_mult (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .a_vec (a_vec),
        .b_vec (b_vec),
        .done  (done),
        .p_vec (p_vec)
    );

    always #2 clk = ~clk;

    // Value is (-1)^sgn * 2^sc * man / 2^12
    function automatic void decode_posit(input posit_t p, output bit sgn, output int sc,
                                         output logic [12:0] man);
        posit_t mag;
        int     j;
        int     run;
        int     k;
        int     fb;
        bit     e;
        sgn = p[15];
        mag = p[15] ? -p : p;
        j   = 14;
        run = 0;
        while (j >= 0 && mag[j] == mag[14])
        begin
            run++;
            j--;
        end
        k = mag[14] ? run - 1 : -run;
        j--;                                  // Skip the regime terminator
        e = 1'b0;
        if (j >= 0)
        begin
            e = mag[j];
            j--;
        end
        man = 13'h1000;                       // Hidden bit
        fb  = 11;
        while (j >= 0)
        begin
            man[fb] = mag[j];
            fb--;
            j--;
        end
        sc = 2 * k + int'(e);
    endfunction

    // Builds the unbounded bit string, then rounds the pattern to 15 body bits
    function automatic posit_t encode_posit(bit sgn, int sc, logic [24:0] fr);
        logic [63:0] bits;
        logic [14:0] body;
        logic [14:0] mag;
        int          pos;
        int          k;
        int          j;
        bit          guard;
        bit          sticky;
        if (sc >= 28)
            mag = 15'h7FFF;                   // maxpos
        else if (sc < -28)
            mag = 15'h0001;                   // minpos
        else
        begin
            k    = sc >>> 1;
            bits = '0;
            pos  = 63;
            if (k >= 0)
            begin
                for (j = 0; j <= k; j++)
                begin
                    bits[pos] = 1'b1;
                    pos--;
                end
                pos--;                        // Zero terminator
            end
            else
            begin
                pos = pos + k;
                bits[pos] = 1'b1;
                pos--;
            end
            bits[pos] = sc[0];                // Exponent bit
            pos--;
            for (j = 24; j >= 0; j--)
            begin
                bits[pos] = fr[j];
                pos--;
            end
            body   = bits[63:49];
            guard  = bits[48];
            sticky = |bits[47:0];
            mag    = body + 15'(guard & (sticky | body[0]));
        end
        return sgn ? -{1'b0, mag} : {1'b0, mag};
    endfunction

    function automatic posit_t mult_model(posit_t a, posit_t b);
        bit          sa, sb;
        int          ea, eb, sc;
        logic [12:0] ma, mb;
        logic [25:0] m;
        logic [24:0] fr;
        posit_t      r;
        if (a == 16'h8000 || b == 16'h8000)
            r = 16'h8000;                     // NaR beats zero
        else if (a == '0 || b == '0)
            r = '0;
        else
        begin
            decode_posit(a, sa, ea, ma);
            decode_posit(b, sb, eb, mb);
            m  = ma * mb;                     // Exact, 24 fraction bits
            sc = ea + eb;
            if (m[25])
            begin
                sc++;
                fr = m[24:0];
            end
            else
                fr = {m[23:0], 1'b0};
            r = encode_posit(sa ^ sb, sc, fr);
        end
        return r;
    endfunction

    function automatic posit_t random_operand();
        posit_t p;
        if ($urandom % 8 == 0)
        begin
            case ($urandom % 8)
                0:       p = 16'h0000;
                1:       p = 16'h8000;        // NaR
                2:       p = 16'h7FFF;        // maxpos
                3:       p = 16'h8001;
                4:       p = 16'h0001;        // minpos
                5:       p = 16'hFFFF;
                6:       p = 16'h4000;        // +1
                default: p = 16'hC000;
            endcase
        end
        else
            p = posit_t'($urandom);
        return p;
    endfunction

    task automatic drive_item();
        posit_vec_t exp_item;
        int         l;
        start = ($urandom % 4) != 0;
        for (l = 0; l < `LANES; l++)
        begin
            a_vec[l]    = random_operand();
            b_vec[l]    = random_operand();
            exp_item[l] = mult_model(a_vec[l], b_vec[l]);
        end
        if (start)
        begin
            exp_q.push_back(exp_item);
            due_q.push_back(cycle + LATENCY);
        end
    endtask

    // Scoreboard samples outputs at the falling edge
    always @(negedge clk)
    begin
        if (rst_n && done)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("done pulse at cycle %0d with no item in flight", cycle);
            end
            else
            begin
                exp_vec = exp_q.pop_front();
                due     = due_q.pop_front();
                if (due != cycle)
                begin
                    errors++;
                    $display("done at cycle %0d but the item was due at cycle %0d", cycle, due);
                end
                for (lane = 0; lane < `LANES; lane++)
                begin
                    if (p_vec[lane] !== exp_vec[lane])
                    begin
                        errors++;
                        $display("Mismatch p_vec lane %0d: got 0x%h expected 0x%h",
                                 lane, p_vec[lane], exp_vec[lane]);
                    end
                end
            end
        end
        else if (rst_n && due_q.size() != 0 && due_q[0] <= cycle)
        begin
            errors++;
            $display("No done pulse for the item due at cycle %0d", due_q[0]);
            due     = due_q.pop_front();
            exp_vec = exp_q.pop_front();
        end
    end

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Timeout at cycle %0d with %0d items pending", cycle, exp_q.size());
            $display("Errors: %0d", errors);
            $display("Test FAILED");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(16288));
        rst_n = 1'b0;
        start = 1'b0;
        a_vec = '0;
        b_vec = '0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        repeat (STIM_CYCLES)
        begin
            @(posedge clk);
            #1 drive_item();
        end
        @(posedge clk);
        #1 start = 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (LATENCY) @(posedge clk);     // Window for stray done pulses
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/posit_pkg.sv
design/posit_unpack.sv
design/raw_mult_lane.sv
design/posit_pack.sv
design/posit_vec_mult.sv
dv/posit_vec_mult_asserts.sv
dv/posit_vec_mult_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the posit multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module posit_vec_mult_tb -o posit_vec_mult_sim

# The run passes only when the pass line is printed
out=$(./obj_dir/posit_vec_mult_sim 2>&1) || true
echo "$out"
echo "$out" | grep -qx "Test OK"
